// File: exec_stim.txt
// func data1 data2 shamt res_lo res_hi flags, all hex; flags = {zero, div_zero}
// a line "idle N" inserts N idle cycles
00 00000005 00000003 00 00000008 00000000 0
00 ffffffff 00000001 00 00000000 00000000 2
01 12345678 12345678 00 00000000 00000000 2
01 00000003 00000005 00 fffffffe 00000000 0
05 ff00ff00 0ff00ff0 00 0f000f00 00000000 0
06 ff00ff00 0ff00ff0 00 fff0fff0 00000000 0
07 ff00ff00 0ff00ff0 00 000f000f 00000000 0
08 ff00ff00 0ff00ff0 00 f0f0f0f0 00000000 0
09 ffffffff 00000001 00 00000001 00000000 0
0a ffffffff 00000001 00 00000000 00000000 2
idle 3
02 00000001 00000000 04 00000010 00000000 0
03 80000000 00000000 04 08000000 00000000 0
04 80000000 00000000 04 f8000000 00000000 0
04 7ffffff0 00000000 04 07ffffff 00000000 0
0b fffffffe 00000003 00 fffffffa ffffffff 0
0c fffffffe 00000003 00 fffffffa 00000002 0
12 00000000 00000000 00 00000002 00000000 0
11 00000000 00000000 00 fffffffa 00000000 0
0d fffffff9 00000002 00 fffffffd ffffffff 0
0e 00000007 00000002 00 00000003 00000001 0
0e 12345678 00000000 00 ffffffff 12345678 1
0d 00000000 00000000 00 ffffffff 00000000 1
idle 2
10 cafef00d 00000000 00 cafef00d cafef00d 0
12 00000000 00000000 00 cafef00d 00000000 0
0f 0badbeef 00000000 00 0badbeef 00000000 0
11 00000000 00000000 00 0badbeef 00000000 0
1f 00000042 00000007 03 00000042 00000000 0

// File: list.f
exec_pkg.sv
alu_core.sv
hilo_regs.sv
exec_ctrl.sv
exec_top.sv
exec_checker.sv
tb_exec.sv

// File: Makefile
# Verilator simulation of the execute unit

VERILATOR ?= verilator
TOP       ?= tb_exec
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

.PHONY: sim clean

// File: tb_exec.sv
// execute unit testbench
`timescale 1ns/1ps
`default_nettype none

module tb_exec;
	import exec_pkg::*;

	logic      clk;
	logic      rst_n;
	logic      in_valid;
	exec_req_t in_req;
	logic      out_valid;
	exec_rsp_t out_rsp;
	int        err_count;
	int        rsp_count;
	int        req_count;
	int        tb_errors;
	int        wait_cnt;

	always #2 clk = ~clk; // 4 ns period

	exec_top u_dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_req    (in_req),
		.out_valid (out_valid),
		.out_rsp   (out_rsp)
	);

	exec_checker u_chk (
		.clk       (clk),
		.rst_n     (rst_n),
		.out_valid (out_valid),
		.out_rsp   (out_rsp),
		.err_count (err_count),
		.rsp_count (rsp_count)
	);

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(negedge clk);
			in_valid = 1'b0;
		end
	endtask

	task automatic send_req(input logic [31:0] f, input logic [31:0] d1,
			input logic [31:0] d2, input logic [31:0] sh);
		@(negedge clk);
		in_valid     = 1'b1;
		in_req.func  = alu_func_t'(f[4:0]); // unknown codes allowed
		in_req.data1 = d1;
		in_req.data2 = d2;
		in_req.shamt = sh[4:0];
		req_count++;
	endtask

	// ----------------------------------------------------------------------
	// stimulus file pass
	// ----------------------------------------------------------------------
	task automatic run_file(input bit with_gaps);
		int          fd;
		int          n;
		string       line;
		logic [31:0] f, d1, d2, sh, e_lo, e_hi, e_fl;
		fd = $fopen("exec_stim.txt", "r");
		if (fd == 0) begin
			$display("cannot open stimulus file exec_stim.txt");
			tb_errors++;
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if ($sscanf(line, "idle %d", n) == 1) begin
				idle_cycles(n);
			end else if ($sscanf(line, "%h %h %h %h %h %h %h",
					f, d1, d2, sh, e_lo, e_hi, e_fl) == 7) begin
				send_req(f, d1, d2, sh);
				if (with_gaps)
					idle_cycles($urandom % 3); // 0..2 extra idle cycles
			end
		end
		$fclose(fd);
	endtask

	initial begin
		clk       = 1'b0;
		rst_n     = 1'b0;
		in_valid  = 1'b0;
		in_req    = '0;
		req_count = 0;
		tb_errors = 0;
		void'($urandom(7));
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		run_file(1'b1); // random gaps
		run_file(1'b0); // back to back
		idle_cycles(1);

		wait_cnt = 0;
		while (rsp_count < req_count && wait_cnt < 200) begin
			@(negedge clk);
			wait_cnt++;
		end
		if (rsp_count < req_count) begin
			$display("timeout: only %0d of %0d results arrived", rsp_count, req_count);
			tb_errors++;
		end
		idle_cycles(4); // catch stray pulses
		if (rsp_count != req_count && rsp_count >= req_count) begin
			$display("result count %0d does not match request count %0d",
				rsp_count, req_count);
			tb_errors++;
		end

		$display("checker errors %0d, testbench errors %0d, results %0d of %0d requests",
			err_count, tb_errors, rsp_count, req_count);
		if (err_count == 0 && tb_errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: exec_checker.sv
// execute unit result checker
`timescale 1ns/1ps
`default_nettype none

module exec_checker (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                out_valid,
	input  exec_pkg::exec_rsp_t out_rsp,
	output int                  err_count,
	output int                  rsp_count
);
	import exec_pkg::*;

	exec_rsp_t exp_q[$];

	task automatic load_expected();
		int          fd;
		string       line;
		logic [31:0] f, d1, d2, sh, e_lo, e_hi, e_fl;
		exec_rsp_t   e;
		fd = $fopen("exec_stim.txt", "r");
		if (fd == 0) begin
			$display("checker cannot open exec_stim.txt");
			err_count++;
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if ($sscanf(line, "%h %h %h %h %h %h %h",
					f, d1, d2, sh, e_lo, e_hi, e_fl) == 7) begin
				e.res_lo   = e_lo;
				e.res_hi   = e_hi;
				e.zero     = e_fl[1];
				e.div_zero = e_fl[0];
				exp_q.push_back(e);
			end
		end
		$fclose(fd);
	endtask

	task automatic compare_field(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("Mismatch %s: got 0x%h expected 0x%h (result %0d)",
				name, got, exp, rsp_count);
			err_count++;
		end
	endtask

	// ----------------------------------------------------------------------
	// compare each pulse with the next expected line
	// ----------------------------------------------------------------------
	task automatic check_rsp();
		exec_rsp_t e;
		rsp_count++;
		if (exp_q.size() == 0) begin
			$display("out_valid pulse %0d arrived with no expected result left", rsp_count);
			err_count++;
			return;
		end
		e = exp_q.pop_front();
		compare_field("res_lo", out_rsp.res_lo, e.res_lo);
		compare_field("res_hi", out_rsp.res_hi, e.res_hi);
		compare_field("zero", {31'b0, out_rsp.zero}, {31'b0, e.zero});
		compare_field("div_zero", {31'b0, out_rsp.div_zero}, {31'b0, e.div_zero});
	endtask

	initial begin
		err_count = 0;
		rsp_count = 0;
		load_expected(); // random-gap pass
		load_expected(); // back-to-back pass
		forever begin
			@(negedge clk); // outputs settled
			if (rst_n && out_valid)
				check_rsp();
		end
	end

endmodule

`default_nettype wire

// File: exec_top.sv
// execute unit top
`timescale 1ns/1ps
`default_nettype none

module exec_top (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                in_valid,
	input  exec_pkg::exec_req_t in_req,
	output logic                out_valid,
	output exec_pkg::exec_rsp_t out_rsp
);
	import exec_pkg::*;

	exec_req_t         stage_req;
	exec_rsp_t         alu_rsp;
	logic              hi_we;
	logic              lo_we;
	logic [data_w-1:0] hi_val;
	logic [data_w-1:0] lo_val;

	exec_ctrl u_ctrl (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_req    (in_req),
		.stage_req (stage_req),
		.alu_rsp   (alu_rsp),
		.hi_we     (hi_we),
		.lo_we     (lo_we),
		.out_valid (out_valid),
		.out_rsp   (out_rsp)
	);

	alu_core u_alu (
		.req    (stage_req),
		.hi_val (hi_val),
		.lo_val (lo_val),
		.rsp    (alu_rsp)
	);

	hilo_regs u_hilo (
		.clk    (clk),
		.rst_n  (rst_n),
		.hi_we  (hi_we),
		.lo_we  (lo_we),
		.hi_in  (alu_rsp.res_hi), // mthi puts data1 here
		.lo_in  (alu_rsp.res_lo),
		.hi_val (hi_val),
		.lo_val (lo_val)
	);

endmodule

`default_nettype wire

// File: exec_ctrl.sv
// execute pipeline control
`timescale 1ns/1ps
`default_nettype none

module exec_ctrl (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                in_valid,
	input  exec_pkg::exec_req_t in_req,
	output exec_pkg::exec_req_t stage_req,
	input  exec_pkg::exec_rsp_t alu_rsp,
	output logic                hi_we,
	output logic                lo_we,
	output logic                out_valid,
	output exec_pkg::exec_rsp_t out_rsp
);
	import exec_pkg::*;

	logic stage_vld;
	logic hi_hit;
	logic lo_hit;

	// ----------------------------------------------------------------------
	// request stage
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			stage_vld <= 1'b0;
		else
			stage_vld <= in_valid;
	end

	always_ff @(posedge clk) begin
		if (in_valid)
			stage_req <= in_req; // payload only
	end

	// hi/lo write decode
	always_comb begin
		hi_hit = 1'b0;
		lo_hit = 1'b0;
		case (stage_req.func)
			muls, mulu, divs, divu: begin
				hi_hit = 1'b1;
				lo_hit = 1'b1;
			end
			mthi:    hi_hit = 1'b1;
			mtlo:    lo_hit = 1'b1;
			default: ;
		endcase
	end

	assign hi_we = stage_vld & hi_hit;
	assign lo_we = stage_vld & lo_hit;

	// ----------------------------------------------------------------------
	// response stage
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			out_valid <= 1'b0;
		else
			out_valid <= stage_vld; // one pulse per request
	end

	always_ff @(posedge clk) begin
		if (stage_vld)
			out_rsp <= alu_rsp;
	end

	// ----------------------------------------------------------------------
	// checks
	// ----------------------------------------------------------------------
	a_out_follows: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid == $past(stage_vld));

	a_we_gated: assert property (@(posedge clk) disable iff (!rst_n)
		(hi_we || lo_we) |-> stage_vld);

endmodule

`default_nettype wire

// File: hilo_regs.sv
// HI/LO register pair
`timescale 1ns/1ps
`default_nettype none

module hilo_regs (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        hi_we,
	input  logic                        lo_we,
	input  logic [exec_pkg::data_w-1:0] hi_in,
	input  logic [exec_pkg::data_w-1:0] lo_in,
	output logic [exec_pkg::data_w-1:0] hi_val,
	output logic [exec_pkg::data_w-1:0] lo_val
);
	import exec_pkg::*;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			hi_val <= {data_w{1'b0}};
		else if (hi_we)
			hi_val <= hi_in;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			lo_val <= {data_w{1'b0}};
		else if (lo_we)
			lo_val <= lo_in;
	end

	// ----------------------------------------------------------------------
	// checks
	// ----------------------------------------------------------------------
	a_hi_hold: assert property (@(posedge clk) disable iff (!rst_n)
		!hi_we |=> $stable(hi_val));

	a_lo_hold: assert property (@(posedge clk) disable iff (!rst_n)
		!lo_we |=> $stable(lo_val));

endmodule

`default_nettype wire

// File: alu_core.sv
// execute ALU
`timescale 1ns/1ps
`default_nettype none

module alu_core (
	input  exec_pkg::exec_req_t         req,
	input  logic [exec_pkg::data_w-1:0] hi_val,
	input  logic [exec_pkg::data_w-1:0] lo_val,
	output exec_pkg::exec_rsp_t         rsp
);
	import exec_pkg::*;

	logic [2*data_w-1:0] prod_s;
	logic [2*data_w-1:0] prod_u;
	logic                by_zero;
	logic [data_w-1:0]   den;
	logic [data_w-1:0]   quo_s;
	logic [data_w-1:0]   rem_s;
	logic [data_w-1:0]   quo_u;
	logic [data_w-1:0]   rem_u;
	logic [data_w-1:0]   res_lo;
	logic [data_w-1:0]   res_hi;
	logic                div_zero;

	// ----------------------------------------------------------------------
	// multiply and divide datapath
	// ----------------------------------------------------------------------
	assign prod_s = $signed(req.data1) * $signed(req.data2);
	assign prod_u = req.data1 * req.data2; // zero extended to 64

	assign by_zero = (req.data2 == '0);
	assign den     = by_zero ? data_w'(1) : req.data2; // keep the divider defined

	assign quo_s = $signed(req.data1) / $signed(den);
	assign rem_s = $signed(req.data1) % $signed(den);
	assign quo_u = req.data1 / den;
	assign rem_u = req.data1 % den;

	// ----------------------------------------------------------------------
	// result select
	// ----------------------------------------------------------------------
	always_comb begin
		res_lo   = req.data1;
		res_hi   = '0;
		div_zero = 1'b0;
		case (req.func)
			add:    res_lo = req.data1 + req.data2;
			sub:    res_lo = req.data1 - req.data2;
			sll:    res_lo = req.data1 << req.shamt;
			srl:    res_lo = req.data1 >> req.shamt;
			sra:    res_lo = $signed(req.data1) >>> req.shamt; // sign fill
			and_op: res_lo = req.data1 & req.data2;
			or_op:  res_lo = req.data1 | req.data2;
			nor_op: res_lo = ~(req.data1 | req.data2);
			xor_op: res_lo = req.data1 ^ req.data2;
			slts:   res_lo = data_w'($signed(req.data1) < $signed(req.data2));
			sltu:   res_lo = data_w'(req.data1 < req.data2);
			muls: begin
				res_lo = prod_s[data_w-1:0];
				res_hi = prod_s[2*data_w-1:data_w];
			end
			mulu: begin
				res_lo = prod_u[data_w-1:0];
				res_hi = prod_u[2*data_w-1:data_w];
			end
			divs: begin
				res_lo   = by_zero ? '1 : quo_s;
				res_hi   = by_zero ? req.data1 : rem_s;
				div_zero = by_zero;
			end
			divu: begin
				res_lo   = by_zero ? '1 : quo_u;
				res_hi   = by_zero ? req.data1 : rem_u;
				div_zero = by_zero;
			end
			mtlo:   res_lo = req.data1;
			mthi: begin
				res_lo = req.data1;
				res_hi = req.data1; // lands in hi
			end
			mflo:   res_lo = lo_val;
			mfhi:   res_lo = hi_val;
			default: begin
				res_lo = req.data1; // unknown code
				res_hi = '0;
			end
		endcase
	end

	assign rsp.res_lo   = res_lo;
	assign rsp.res_hi   = res_hi;
	assign rsp.zero     = ~(|res_lo);
	assign rsp.div_zero = div_zero;

	// ----------------------------------------------------------------------
	// checks
	// ----------------------------------------------------------------------
	always_comb begin
		if (rsp.div_zero) begin
			a_div_zero: assert ((req.func == divs || req.func == divu) && req.data2 == '0);
		end
	end

endmodule

`default_nettype wire

// File: exec_pkg.sv
// execute unit shared types
`default_nettype none

package exec_pkg;

	// ----------------------------------------------------------------------
	// widths
	// ----------------------------------------------------------------------
	localparam int data_w  = 32;
	localparam int shamt_w = 5;

	// ----------------------------------------------------------------------
	// alu function codes
	// ----------------------------------------------------------------------
	typedef enum logic [4:0] {
		add    = 5'h00,
		sub    = 5'h01,
		sll    = 5'h02,
		srl    = 5'h03,
		sra    = 5'h04,
		and_op = 5'h05,
		or_op  = 5'h06,
		nor_op = 5'h07,
		xor_op = 5'h08,
		slts   = 5'h09,
		sltu   = 5'h0a,
		muls   = 5'h0b,
		mulu   = 5'h0c,
		divs   = 5'h0d,
		divu   = 5'h0e,
		mtlo   = 5'h0f,
		mthi   = 5'h10,
		mflo   = 5'h11,
		mfhi   = 5'h12
	} alu_func_t; // codes above 5'h12 pass data1 through

	typedef struct packed {
		alu_func_t           func;
		logic [data_w-1:0]   data1;
		logic [data_w-1:0]   data2;
		logic [shamt_w-1:0]  shamt;
	} exec_req_t; // 74 bits

	typedef struct packed {
		logic [data_w-1:0] res_lo;
		logic [data_w-1:0] res_hi;
		logic              zero;
		logic              div_zero;
	} exec_rsp_t; // 66 bits

endpackage

`default_nettype wire
